// File: hw/heapPkg.sv
/*
  Shared sizes, command and error encodings and the request and response
  structs of the array heap. Every heap module refers to these by scoped name.
*/
package heapPkg;

  // Sizes ------------------------------
  localparam int arrayBits   = 2;                  // Address width
  localparam int arrays      = 2 ** arrayBits;     // Four arrays
  localparam int indexBits   = 3;                  // Element index width
  localparam int arrayLength = 2 ** indexBits;     // Eight elements per array
  localparam int dataBits    = 16;                 // Element width

  typedef logic [indexBits:0]    sizeT;            // Size 0 to 8
  typedef logic [arrayBits-1:0]  arrayT;           // Array number
  typedef logic [indexBits-1:0]  indexT;           // Element index
  typedef logic [dataBits-1:0]   dataT;            // Element value

  // Encodings --------------------------
  typedef enum logic [4:0] {
    actNone,                                       // Idle cycle
    actAlloc,                                      // Allocate an array
    actFree,                                       // Return an array to the free stack
    actWrite,                                      // Write, extending the size
    actRead,                                       // Read an element
    actSize,                                       // Size of array
    actInc,                                        // Grow by one
    actDec,                                        // Shrink by one
    actResize,                                     // Load size from data
    actPush,                                       // Append at size
    actPop,                                        // Remove last element
    actIndex,                                      // Last match position plus one
    actLess,                                       // Count of elements below data
    actGreater,                                    // Count of elements above data
    actAdd,                                        // Add, new value back
    actAddAfter,                                   // Add, old value back
    actSubtract,                                   // Subtract, new value back
    actSubAfter,                                   // Subtract, old value back
    actShiftLeft,
    actShiftRight,
    actNot,                                        // Bitwise invert
    actOr,
    actXor,
    actAnd
  } actionT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                               // At or above high water
    errFreed,                                      // Below high water but released
    errOutOfBounds,                                // Index at or beyond size
    errFull,                                       // Push or Inc at size 8
    errEmpty,                                      // Pop or Dec at size 0
    errTooLarge,                                   // Resize above 8
    errOutOfMemory                                 // Alloc with nothing left
  } errorT;

  // Bus structs ------------------------
  typedef struct packed {
    actionT action;                                // Command strobe
    arrayT  array;                                 // Addressed array
    indexT  index;                                 // Element position
    dataT   data;                                  // Operand
  } heapRequestT;

  typedef struct packed {
    dataT  data;                                   // Result value
    errorT error;                                  // Failure reason
  } heapResponseT;

  // Read-modify-write commands, all bounds checked against size
  function automatic logic isElementOp(actionT action);
    return action inside {actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft,
                          actShiftRight, actNot, actOr, actXor, actAnd};
  endfunction

endpackage

// File: hw/heapAllocator.sv
/*
  Array allocator of the heap. Hands out never-used arrays up to a high-water
  count and reuses freed ones from a stack, and classifies each array access.
*/
`timescale 1ns/1ps

module heapAllocator (
  input  logic            clock,
  input  logic            resetN,
  input  heapPkg::actionT action,
  input  heapPkg::arrayT  array,
  input  logic            commit,                  // Command has no error
  output heapPkg::errorT  accessError,
  output heapPkg::arrayT  allocArray,              // Next Alloc result
  output logic            allocFail                // Nothing left to hand out
);

  typedef logic [heapPkg::arrayBits:0] countT;     // Counts 0 to arrays

  heapPkg::arrayT             freedStack [heapPkg::arrays];   // Released array numbers
  countT                      freedTop;            // Entries on the stack
  countT                      highWater;           // Arrays ever handed out
  logic [heapPkg::arrays-1:0] allocated;           // Live flag per array
  logic                       reuse;               // Take from stack first

  assign reuse     = freedTop != '0;
  assign allocFail = !reuse && highWater == countT'(heapPkg::arrays);

  always_comb begin
    if (reuse) begin
      allocArray = freedStack[heapPkg::arrayT'(freedTop - 1'b1)];  // Most recently freed
    end else begin
      allocArray = heapPkg::arrayT'(highWater);    // Fresh array
    end
  end

  // Access check -----------------------
  always_comb begin
    if (countT'(array) >= highWater) begin
      accessError = heapPkg::errNotAllocated;      // Never handed out
    end else if (!allocated[array]) begin
      accessError = heapPkg::errFreed;             // Also catches a double free
    end else begin
      accessError = heapPkg::errNone;
    end
  end

  // State update -----------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freedTop  <= '0;                             // Everything free again
      highWater <= '0;
      allocated <= '0;
    end else if (commit) begin
      if (action == heapPkg::actAlloc) begin
        if (reuse) begin
          freedTop <= freedTop - 1'b1;             // Pop the stack
        end else begin
          highWater <= highWater + 1'b1;           // Claim a new array
        end
        allocated[allocArray] <= 1'b1;
      end else if (action == heapPkg::actFree) begin
        freedTop          <= freedTop + 1'b1;      // Push the stack
        allocated[array]  <= 1'b0;
      end
    end
  end

  // Stack never holds more than highWater entries, so the push slot stays in range
  always_ff @(posedge clock) begin
    if (commit && action == heapPkg::actFree) begin
      freedStack[heapPkg::arrayT'(freedTop)] <= array;
    end
  end

endmodule

// File: hw/heapSizeTable.sv
/*
  Size of every heap array. Reports the bounds, full, empty and resize errors
  of the current command and applies its size change once it commits.
*/
`timescale 1ns/1ps

module heapSizeTable (
  input  logic            clock,
  input  logic            resetN,
  input  heapPkg::actionT action,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,                   // Request index, not the effective one
  input  heapPkg::dataT   data,                    // New size for Resize
  input  heapPkg::arrayT  allocArray,              // Array an Alloc would claim
  input  logic            commit,
  output heapPkg::sizeT   size,                    // Size of addressed array
  output heapPkg::errorT  sizeError
);

  heapPkg::sizeT sizes [heapPkg::arrays];          // One size per array
  logic          boundsCheck;                      // Index must be below size

  assign size        = sizes[array];
  assign boundsCheck = action == heapPkg::actRead || heapPkg::isElementOp(action);

  // Size errors ------------------------
  always_comb begin
    sizeError = heapPkg::errNone;
    case (action)
      heapPkg::actPush, heapPkg::actInc: begin
        if (size == heapPkg::sizeT'(heapPkg::arrayLength)) begin
          sizeError = heapPkg::errFull;            // No room left
        end
      end
      heapPkg::actPop, heapPkg::actDec: begin
        if (size == '0) begin
          sizeError = heapPkg::errEmpty;           // Nothing to remove
        end
      end
      heapPkg::actResize: begin
        if (data > heapPkg::dataT'(heapPkg::arrayLength)) begin
          sizeError = heapPkg::errTooLarge;
        end
      end
      default: begin
        if (boundsCheck && heapPkg::sizeT'(index) >= size) begin
          sizeError = heapPkg::errOutOfBounds;     // Read past the end
        end
      end
    endcase
  end

  // Size updates -----------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::arrays; i++) begin
        sizes[i] <= '0;                            // All arrays empty
      end
    end else if (commit) begin
      case (action)
        heapPkg::actWrite: begin
          if (heapPkg::sizeT'(index) >= size) begin
            sizes[array] <= heapPkg::sizeT'(index + 1);  // Grow to cover the write
          end
        end
        heapPkg::actInc, heapPkg::actPush: begin
          sizes[array] <= size + 1'b1;
        end
        heapPkg::actDec, heapPkg::actPop: begin
          sizes[array] <= size - 1'b1;
        end
        heapPkg::actResize: begin
          sizes[array] <= heapPkg::sizeT'(data);   // Range checked above
        end
        heapPkg::actAlloc: begin
          sizes[allocArray] <= '0;                 // New array starts empty
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: hw/heapElements.sv
/*
  Element storage of the heap with its read-modify-write operator unit.
  Reads are combinational at the effective index, writes land on the clock
  edge of a committed command. The whole addressed array goes to the search.
*/
`timescale 1ns/1ps

module heapElements (
  input  logic            clock,
  input  heapPkg::actionT action,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,                   // Effective index from the top
  input  heapPkg::dataT   data,                    // Operand or value to store
  input  logic            commit,
  output heapPkg::dataT   elementData,             // Value before the operation
  output heapPkg::dataT   opResult,                // Value after the operation
  output heapPkg::dataT   arrayData [heapPkg::arrayLength]
);

  heapPkg::dataT mem [heapPkg::arrays][heapPkg::arrayLength];  // Fixed blocks per array
  logic          store;                            // Write back this cycle

  assign elementData = mem[array][index];

  // Operator unit ----------------------
  always_comb begin
    case (action)
      heapPkg::actWrite, heapPkg::actPush: begin
        opResult = data;                           // Plain store
      end
      heapPkg::actAdd, heapPkg::actAddAfter: begin
        opResult = elementData + data;
      end
      heapPkg::actSubtract, heapPkg::actSubAfter: begin
        opResult = elementData - data;
      end
      heapPkg::actShiftLeft: begin
        opResult = elementData << data;            // Large amounts give zero
      end
      heapPkg::actShiftRight: begin
        opResult = elementData >> data;
      end
      heapPkg::actNot: begin
        opResult = ~elementData;                   // Operand ignored
      end
      heapPkg::actOr: begin
        opResult = elementData | data;
      end
      heapPkg::actXor: begin
        opResult = elementData ^ data;
      end
      heapPkg::actAnd: begin
        opResult = elementData & data;
      end
      default: begin
        opResult = elementData;                    // Unchanged
      end
    endcase
  end

  // Storage ----------------------------
  assign store = commit && (action == heapPkg::actWrite || action == heapPkg::actPush ||
                            heapPkg::isElementOp(action));

  always_ff @(posedge clock) begin
    if (store) begin
      mem[array][index] <= opResult;
    end
  end

  always_comb begin
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      arrayData[i] = mem[array][i];                // Addressed array for scans
    end
  end

endmodule

// File: hw/heapSearch.sv
/*
  Search scans of the heap over the addressed array, limited to its size.
  Index gives the last matching position plus one, Less and Greater a count.
*/
`timescale 1ns/1ps

module heapSearch (
  input  heapPkg::actionT action,
  input  heapPkg::dataT   arrayData [heapPkg::arrayLength],
  input  heapPkg::sizeT   size,                    // Live elements
  input  heapPkg::dataT   data,                    // Search key
  output heapPkg::sizeT   searchCount
);

  always_comb begin
    searchCount = '0;                              // No match or not a search
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      if (i < size) begin                          // Skip dead slots
        case (action)
          heapPkg::actIndex: begin
            if (arrayData[i] == data) begin
              searchCount = heapPkg::sizeT'(i + 1);  // Later match wins
            end
          end
          heapPkg::actLess: begin
            if (arrayData[i] < data) begin
              searchCount = searchCount + 1'b1;
            end
          end
          heapPkg::actGreater: begin
            if (arrayData[i] > data) begin
              searchCount = searchCount + 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: hw/heapMemory.sv
/*
  Top of the array heap. Decodes each request, ranks the errors of the
  submodules, commits error-free commands and registers the response with a
  one-cycle done pulse on the following edge.
*/
`timescale 1ns/1ps

module heapMemory (
  input  logic                  clock,
  input  logic                  resetN,
  input  heapPkg::heapRequestT  request,           // Any action but none is a command
  output heapPkg::heapResponseT response,
  output logic                  done
);

  heapPkg::actionT action;
  heapPkg::arrayT  array;
  heapPkg::dataT   data;
  heapPkg::errorT  accessError;
  heapPkg::errorT  sizeError;
  heapPkg::errorT  cmdError;                       // Ranked error of this command
  heapPkg::arrayT  allocArray;
  logic            allocFail;
  logic            commit;
  heapPkg::sizeT   size;
  heapPkg::indexT  effIndex;                       // Element position actually used
  heapPkg::dataT   elementData;
  heapPkg::dataT   opResult;
  heapPkg::dataT   arrayData [heapPkg::arrayLength];
  heapPkg::sizeT   searchCount;
  heapPkg::dataT   respData;

  assign action = request.action;
  assign array  = request.array;
  assign data   = request.data;

  // Decode -----------------------------
  always_comb begin
    if (action == heapPkg::actAlloc) begin
      cmdError = allocFail ? heapPkg::errOutOfMemory : heapPkg::errNone;  // No access check
    end else if (action == heapPkg::actNone) begin
      cmdError = heapPkg::errNone;
    end else if (accessError != heapPkg::errNone) begin
      cmdError = accessError;                      // Access outranks size
    end else begin
      cmdError = sizeError;
    end
  end

  assign commit = action != heapPkg::actNone && cmdError == heapPkg::errNone;

  always_comb begin
    case (action)
      heapPkg::actPush: effIndex = heapPkg::indexT'(size);           // Slot past the end
      heapPkg::actPop:  effIndex = heapPkg::indexT'(size - 1'b1);    // Last live slot
      default:          effIndex = request.index;
    endcase
  end

  heapAllocator allocator (
    .clock, .resetN, .action, .array, .commit, .accessError, .allocArray, .allocFail
  );

  heapSizeTable sizeTable (
    .clock, .resetN, .action, .array, .index(request.index), .data, .allocArray,
    .commit, .size, .sizeError
  );

  heapElements elements (
    .clock, .action, .array, .index(effIndex), .data, .commit, .elementData,
    .opResult, .arrayData
  );

  heapSearch search (.action, .arrayData, .size, .data, .searchCount);

  // Response ---------------------------
  always_comb begin
    case (action)
      heapPkg::actWrite:                        respData = data;
      heapPkg::actRead, heapPkg::actPop,
      heapPkg::actAddAfter, heapPkg::actSubAfter: respData = elementData;  // Old value
      heapPkg::actSize:                         respData = heapPkg::dataT'(size);
      heapPkg::actAlloc:                        respData = heapPkg::dataT'(allocArray);
      heapPkg::actIndex, heapPkg::actLess,
      heapPkg::actGreater:                      respData = heapPkg::dataT'(searchCount);
      heapPkg::actAdd, heapPkg::actSubtract, heapPkg::actShiftLeft, heapPkg::actShiftRight,
      heapPkg::actNot, heapPkg::actOr, heapPkg::actXor,
      heapPkg::actAnd:                          respData = opResult;   // New value
      default:                                  respData = '0;
    endcase
    if (cmdError != heapPkg::errNone) begin
      respData = '0;                               // Failed commands return nothing
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      response <= '0;
      done     <= 1'b0;
    end else begin
      done <= action != heapPkg::actNone;          // Pulse one cycle after the command
      if (action != heapPkg::actNone) begin
        response.data  <= respData;
        response.error <= cmdError;
      end
    end
  end

endmodule

// File: test/heapMemoryChk.sv
/*
  Timing assertions of the heap top level, bound into every heapMemory.
  Covers the done pulse, done under reset and zero data on errors.
*/
`timescale 1ns/1ps

module heapMemoryChk (
  input logic                  clock,
  input logic                  resetN,
  input heapPkg::heapRequestT  request,
  input heapPkg::heapResponseT response,
  input logic                  done
);

  // One done per command, one cycle later
  doneFollowsCommand: assert property (
    @(posedge clock) disable iff (!resetN)
    done == $past(request.action != heapPkg::actNone)
  ) else $error("done does not follow the command strobe");

  // Reset holds done low
  doneLowInReset: assert property (
    @(posedge clock) !resetN |=> !done
  ) else $error("done high while reset is asserted");

  errorClearsData: assert property (
    @(posedge clock) disable iff (!resetN)
    response.error != heapPkg::errNone |-> response.data == '0
  ) else $error("response data not zero on an error");

endmodule

bind heapMemory heapMemoryChk chk (.clock, .resetN, .request, .response, .done);

// File: test/heapMemoryTb.sv
/*
  Directed testbench of the array heap. A reference model predicts each
  response from the command rules, and every test task ends with one summary line.
*/
`timescale 1ns/1ps

module heapMemoryTb;

  localparam int maxCycles = 400;                  // About 125 commands at 2 cycles, plus resets

  logic                  clock;
  logic                  resetN;
  heapPkg::heapRequestT  request;
  heapPkg::heapResponseT response;
  logic                  done;

  int seed;                                        // $random state
  int cycles = 0;
  int checks;
  int errors;
  int testErrors;                                  // Errors of the running test
  int tests;

  // Reference model --------------------
  int            refSize [heapPkg::arrays];
  heapPkg::dataT refElem [heapPkg::arrays][heapPkg::arrayLength];
  bit            refLive [heapPkg::arrays];
  int            refFreed [$];                     // Released arrays, top at the back
  int            refHigh;                          // Arrays ever handed out

  heapMemory dut (.clock, .resetN, .request, .response, .done);

  always #4 clock = ~clock;                        // 8 ns period

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= maxCycles) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic heapPkg::dataT randomData();
    return heapPkg::dataT'($random(seed));
  endfunction

  function automatic int randomBelow(int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  // New element value for one operator command
  function automatic heapPkg::dataT applyOp(heapPkg::actionT op, heapPkg::dataT old,
                                            heapPkg::dataT operand);
    case (op)
      heapPkg::actAdd, heapPkg::actAddAfter:      return old + operand;
      heapPkg::actSubtract, heapPkg::actSubAfter: return old - operand;
      heapPkg::actShiftLeft:                      return old << operand;
      heapPkg::actShiftRight:                     return old >> operand;
      heapPkg::actNot:                            return ~old;
      heapPkg::actOr:                             return old | operand;
      heapPkg::actXor:                            return old ^ operand;
      default:                                    return old & operand;
    endcase
  endfunction

  // Index, Less and Greater over the live part of one array
  function automatic heapPkg::dataT scanArray(heapPkg::actionT op, int a, heapPkg::dataT key);
    int result;
    result = 0;
    for (int i = 0; i < refSize[a]; i++) begin
      if (op == heapPkg::actIndex && refElem[a][i] == key) result = i + 1;  // Last match
      if (op == heapPkg::actLess && refElem[a][i] < key) result++;
      if (op == heapPkg::actGreater && refElem[a][i] > key) result++;
    end
    return heapPkg::dataT'(result);
  endfunction

  // Expected data and error of one command, model updated only on success
  task automatic predict(input heapPkg::heapRequestT r, output heapPkg::dataT d,
                         output heapPkg::errorT e);
    int a;
    int n;
    int i;
    a = r.array;
    n = refSize[a];
    i = r.index;
    d = '0;
    e = heapPkg::errNone;
    if (r.action == heapPkg::actAlloc) begin
      if (refFreed.size() > 0) begin
        a = refFreed.pop_back();                   // Reuse the last freed array
      end else if (refHigh < heapPkg::arrays) begin
        a = refHigh;                               // Next never-used array
        refHigh++;
      end else begin
        e = heapPkg::errOutOfMemory;
        return;
      end
      refLive[a] = 1'b1;
      refSize[a] = 0;
      d = heapPkg::dataT'(a);
    end else if (a >= refHigh) begin
      e = heapPkg::errNotAllocated;
    end else if (!refLive[a]) begin
      e = heapPkg::errFreed;
    end else begin
      case (r.action)
        heapPkg::actFree: begin
          refLive[a] = 1'b0;
          refFreed.push_back(a);
        end
        heapPkg::actWrite: begin
          refElem[a][i] = r.data;
          refSize[a] = (i >= n) ? i + 1 : n;       // Grow to cover the index
          d = r.data;
        end
        heapPkg::actSize: d = heapPkg::dataT'(n);
        heapPkg::actInc, heapPkg::actPush: begin
          if (n == heapPkg::arrayLength) begin
            e = heapPkg::errFull;
          end else begin
            if (r.action == heapPkg::actPush) refElem[a][n] = r.data;
            refSize[a] = n + 1;
          end
        end
        heapPkg::actDec, heapPkg::actPop: begin
          if (n == 0) begin
            e = heapPkg::errEmpty;
          end else begin
            if (r.action == heapPkg::actPop) d = refElem[a][n-1];
            refSize[a] = n - 1;
          end
        end
        heapPkg::actResize: begin
          if (r.data > heapPkg::arrayLength) e = heapPkg::errTooLarge;
          else refSize[a] = r.data;
        end
        heapPkg::actIndex, heapPkg::actLess, heapPkg::actGreater: begin
          d = scanArray(r.action, a, r.data);
        end
        default: begin                             // Read and the operator commands
          if (i >= n) begin
            e = heapPkg::errOutOfBounds;
          end else if (r.action == heapPkg::actRead) begin
            d = refElem[a][i];
          end else begin
            d = applyOp(r.action, refElem[a][i], r.data);
            if (r.action inside {heapPkg::actAddAfter, heapPkg::actSubAfter}) begin
              d = refElem[a][i];                   // Old value back
            end
            refElem[a][i] = applyOp(r.action, refElem[a][i], r.data);
          end
        end
      endcase
    end
  endtask

  // Checks -----------------------------
  task automatic compareData(string signal, heapPkg::dataT got, heapPkg::dataT want);
    checks++;
    if (got !== want) begin
      $display("mismatch %s: got %h, expected %h", signal, got, want);
      errors++;
      testErrors++;
    end
  endtask

  task automatic compareError(string signal, heapPkg::errorT got, heapPkg::errorT want);
    checks++;
    if (got !== want) begin
      $display("mismatch %s: got %h, expected %h", signal, got, want);
      errors++;
      testErrors++;
    end
  endtask

  task automatic compareFlag(string signal, logic got, logic want);
    checks++;
    if (got !== want) begin
      $display("mismatch %s: got %h, expected %h", signal, got, want);
      errors++;
      testErrors++;
    end
  endtask

  task automatic reportTest(string name);
    tests++;
    $display("test %s finished with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  task automatic applyReset();
    @(posedge clock);
    resetN <= 1'b0;
    repeat (2) @(posedge clock);
    compareFlag("done", done, 1'b0);               // Response register cleared
    compareData("response.data", response.data, '0);
    compareError("response.error", response.error, heapPkg::errNone);
    resetN <= 1'b1;
    refFreed.delete();
    refHigh = 0;
    for (int a = 0; a < heapPkg::arrays; a++) begin
      refSize[a] = 0;
      refLive[a] = 1'b0;
    end
  endtask

  // One command, its done pulse and both response checks
  task automatic issue(heapPkg::actionT action, heapPkg::arrayT array, heapPkg::indexT index,
                       heapPkg::dataT data);
    heapPkg::heapRequestT r;
    heapPkg::dataT        want;
    heapPkg::errorT       wantError;
    r.action = action;
    r.array  = array;
    r.index  = index;
    r.data   = data;
    predict(r, want, wantError);
    @(posedge clock);
    request <= r;
    @(negedge clock);
    compareFlag("done", done, 1'b0);               // Previous pulse over
    @(posedge clock);                              // DUT takes the command here
    request.action <= heapPkg::actNone;
    @(negedge clock);
    compareFlag("done", done, 1'b1);               // One cycle after the command
    compareData("response.data", response.data, want);
    compareError("response.error", response.error, wantError);
  endtask

  // Tests ------------------------------
  task automatic testAllocation();
    for (int i = 0; i < heapPkg::arrays; i++) begin
      issue(heapPkg::actAlloc, 0, 0, 0);           // Fresh arrays in order
    end
    issue(heapPkg::actAlloc, 0, 0, 0);             // Out of memory
    issue(heapPkg::actFree, 1, 0, 0);
    issue(heapPkg::actFree, 2, 0, 0);
    issue(heapPkg::actAlloc, 0, 0, 0);             // Array 2 first
    issue(heapPkg::actAlloc, 0, 0, 0);
    issue(heapPkg::actFree, 3, 0, 0);
    issue(heapPkg::actFree, 3, 0, 0);              // Double free
    reportTest("allocation");
  endtask

  task automatic testAccess();
    applyReset();
    issue(heapPkg::actRead, 3, 0, 0);              // Not yet handed out
    issue(heapPkg::actAlloc, 0, 0, 0);
    issue(heapPkg::actAlloc, 0, 0, 0);
    issue(heapPkg::actWrite, 0, 5, randomData());
    issue(heapPkg::actSize, 0, 0, 0);              // Six after the write
    issue(heapPkg::actRead, 0, 5, 0);
    issue(heapPkg::actRead, 0, 7, 0);              // Past the end
    issue(heapPkg::actFree, 1, 0, 0);
    issue(heapPkg::actRead, 1, 0, 0);
    issue(heapPkg::actPush, 1, 0, randomData());
    reportTest("access");
  endtask

  task automatic testStack();
    issue(heapPkg::actAlloc, 0, 0, 0);             // Array 1 again, empty
    for (int i = 0; i <= heapPkg::arrayLength; i++) begin
      issue(heapPkg::actPush, 1, 0, randomData()); // Last one hits full
    end
    for (int i = 0; i <= heapPkg::arrayLength; i++) begin
      issue(heapPkg::actPop, 1, 0, 0);             // Reverse order, then empty
    end
    issue(heapPkg::actInc, 1, 0, 0);
    issue(heapPkg::actInc, 1, 0, 0);
    issue(heapPkg::actDec, 1, 0, 0);
    issue(heapPkg::actSize, 1, 0, 0);
    issue(heapPkg::actResize, 1, 0, 5);
    issue(heapPkg::actResize, 1, 0, 9);            // Too large
    issue(heapPkg::actSize, 1, 0, 0);
    issue(heapPkg::actResize, 1, 0, 8);
    issue(heapPkg::actInc, 1, 0, 0);               // Full
    issue(heapPkg::actResize, 1, 0, 0);
    issue(heapPkg::actDec, 1, 0, 0);               // Empty
    reportTest("stack");
  endtask

  task automatic testElementOps();
    heapPkg::actionT ops [10];
    heapPkg::dataT   operand;
    ops = '{heapPkg::actAdd, heapPkg::actAddAfter, heapPkg::actSubtract, heapPkg::actSubAfter,
            heapPkg::actShiftLeft, heapPkg::actShiftRight, heapPkg::actNot, heapPkg::actOr,
            heapPkg::actXor, heapPkg::actAnd};
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      issue(heapPkg::actWrite, 0, heapPkg::indexT'(i), randomData());
    end
    foreach (ops[k]) begin
      for (int n = 0; n < 3; n++) begin
        operand = randomData();
        if (ops[k] inside {heapPkg::actShiftLeft, heapPkg::actShiftRight}) begin
          operand = operand % 20;                  // Mostly in-range shift amounts
        end
        issue(ops[k], 0, heapPkg::indexT'(randomBelow(heapPkg::arrayLength)), operand);
      end
    end
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      issue(heapPkg::actRead, 0, heapPkg::indexT'(i), 0);
    end
    issue(heapPkg::actResize, 0, 0, 4);
    issue(heapPkg::actAdd, 0, 6, 1);               // Beyond the new size
    reportTest("element operations");
  endtask

  task automatic testSearch();
    heapPkg::dataT pool [3];
    foreach (pool[k]) pool[k] = randomData();
    issue(heapPkg::actAlloc, 0, 0, 0);             // Array 2
    for (int i = 0; i < heapPkg::arrayLength; i++) begin
      issue(heapPkg::actPush, 2, 0, pool[randomBelow(3)]);  // Repeats on purpose
    end
    issue(heapPkg::actPop, 2, 0, 0);
    issue(heapPkg::actPop, 2, 0, 0);               // Stale values left above size
    foreach (pool[k]) begin
      issue(heapPkg::actIndex, 2, 0, pool[k]);
      issue(heapPkg::actLess, 2, 0, pool[k]);
      issue(heapPkg::actGreater, 2, 0, pool[k]);
    end
    issue(heapPkg::actIndex, 2, 0, randomData());
    reportTest("search");
  endtask

  initial begin
    clock      = 1'b0;
    resetN     = 1'b0;
    request    = '0;
    seed       = 74436;
    checks     = 0;
    errors     = 0;
    testErrors = 0;
    tests      = 0;
    applyReset();
    testAllocation();
    testAccess();
    testStack();
    testElementOps();
    testSearch();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/heapPkg.sv
hw/heapAllocator.sv
hw/heapSizeTable.sv
hw/heapElements.sv
hw/heapSearch.sv
hw/heapMemory.sv
test/heapMemoryChk.sv
test/heapMemoryTb.sv

// File: Bender.yml
package:
  name: heap_memory

sources:
  - hw/heapPkg.sv
  - hw/heapAllocator.sv
  - hw/heapSizeTable.sv
  - hw/heapElements.sv
  - hw/heapSearch.sv
  - hw/heapMemory.sv
  - target: test
    files:
      - test/heapMemoryChk.sv
      - test/heapMemoryTb.sv
